/* src/soc_mem_pkg.sv */
// Shared widths and address map for the on-chip memory block.
// Modules import this package inside their bodies and use scoped names
// in their port lists.

package soc_mem_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus and memory widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word_t;        // One bus / RAM data word
	typedef logic [3:0]  wstrb_t;       // One strobe per byte lane
	typedef logic [31:0] byte_addr_t;   // CPU byte address
	typedef logic [14:0] spram_addr_t;  // RAM word address, 32K words
	typedef logic [13:0] bank_addr_t;   // Address inside one 16K bank
	typedef logic [15:0] half_t;        // Bank data half

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Whole SPRAM, 128 kB
	localparam byte_addr_t spram_bytes = 32'd131072;
	localparam byte_addr_t spram_base  = 32'h0000_0000;

	// GPIO register block
	localparam byte_addr_t gpio_out_addr = 32'h0200_0000; // Output register, R/W
	localparam byte_addr_t gpio_in_addr  = 32'h0200_0004; // Synced input pins, RO

	// Everything else reads zero, writes are dropped

endpackage

/* src/spram_bank.sv */
// Behavioral model of one 16K x 16 single-port RAM bank.
// Nibble write mask and registered read, as on the UP5K SPRAM primitive.
// Output holds its last value while the bank is not selected.

module spram_bank (
	input  logic                   clk,
	input  soc_mem_pkg::bank_addr_t address,
	input  soc_mem_pkg::half_t     datain,
	input  logic [3:0]             maskwren,   // One bit per nibble
	input  logic                   wren,
	input  logic                   chipselect,
	output soc_mem_pkg::half_t     dataout
);
	import soc_mem_pkg::*;

	localparam int depth = 2 ** $bits(bank_addr_t); // 16384 entries

	half_t mem [0:depth-1]; // No reset, contents undefined at power up

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (chipselect && wren) begin
			for (int n = 0; n < 4; n++) begin
				if (maskwren[n])
					mem[address][n*4 +: 4] <= datain[n*4 +: 4]; // Only masked nibbles
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Read before write, a write returns the old word
	always_ff @(posedge clk) begin
		if (chipselect)
			dataout <= mem[address];
		// Deselected: keep last word
	end

endmodule

/* src/ice40up5k_spram.sv */
// 32K x 32 RAM, the full 128 kB of SPRAM on a UP5K-class part.
// Four 16K x 16 banks in a two-by-two layout: addr[14] picks the pair,
// each pair holds the low and high half of the word.
// Read data appears one cycle after the address, on every cycle.

module ice40up5k_spram (
	input  logic                     clk,
	input  soc_mem_pkg::wstrb_t      wen,    // Byte write enables, zero for read
	input  soc_mem_pkg::spram_addr_t addr,   // Word address
	input  soc_mem_pkg::word_t       wdata,
	output soc_mem_pkg::word_t       rdata
);
	import soc_mem_pkg::*;

	logic       cs_0, cs_1;       // Pair chip selects
	logic       pair_q;           // Pair addressed last cycle
	logic [3:0] mask_lo, mask_hi; // Nibble masks per half
	logic       wren_lo, wren_hi;
	word_t      rdata_0, rdata_1; // Read words of pair 0 / pair 1

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Select and mask generation
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign cs_0 = !addr[14];
	assign cs_1 = addr[14];

	// Each byte strobe covers two nibbles
	assign mask_lo = {wen[1], wen[1], wen[0], wen[0]};
	assign mask_hi = {wen[3], wen[3], wen[2], wen[2]};
	assign wren_lo = |wen[1:0];
	assign wren_hi = |wen[3:2];

	// Pair select follows the read latency of the banks
	always_ff @(posedge clk) begin
		pair_q <= addr[14];
	end

	assign rdata = pair_q ? rdata_1 : rdata_0; // Mux on last cycle's pair

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Banks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Pair 0, low half
	spram_bank ram00 (
		.clk(clk), .address(addr[13:0]), .datain(wdata[15:0]),
		.maskwren(mask_lo), .wren(wren_lo), .chipselect(cs_0),
		.dataout(rdata_0[15:0])
	);

	// Pair 0, high half
	spram_bank ram01 (
		.clk(clk), .address(addr[13:0]), .datain(wdata[31:16]),
		.maskwren(mask_hi), .wren(wren_hi), .chipselect(cs_0),
		.dataout(rdata_0[31:16])
	);

	// Pair 1, low half
	spram_bank ram10 (
		.clk(clk), .address(addr[13:0]), .datain(wdata[15:0]),
		.maskwren(mask_lo), .wren(wren_lo), .chipselect(cs_1),
		.dataout(rdata_1[15:0])
	);

	// Pair 1, high half
	spram_bank ram11 (
		.clk(clk), .address(addr[13:0]), .datain(wdata[31:16]),
		.maskwren(mask_hi), .wren(wren_hi), .chipselect(cs_1),
		.dataout(rdata_1[31:16])
	);

endmodule

/* src/mem_bus_port.sv */
// CPU-side request decoder for the memory block.
// A one-cycle req strobe is decoded against the address map, strobes go to
// the hit target only, and ready pulses on the next cycle with the read
// data of the target recorded for that request.

module mem_bus_port #(
	parameter int gpio_width = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	// CPU bus
	input  logic                     req,
	input  soc_mem_pkg::byte_addr_t  addr,
	input  soc_mem_pkg::word_t       wdata,
	input  soc_mem_pkg::wstrb_t      wstrb,   // All zero = read
	output soc_mem_pkg::word_t       rdata,
	output logic                     ready,
	// RAM
	output soc_mem_pkg::wstrb_t      ram_wen,
	output soc_mem_pkg::spram_addr_t ram_addr,
	output soc_mem_pkg::word_t       ram_wdata,
	input  soc_mem_pkg::word_t       ram_rdata,
	// GPIO
	output soc_mem_pkg::wstrb_t      gpio_we,
	output soc_mem_pkg::word_t       gpio_wdata,
	input  logic [gpio_width-1:0]    gpio_out_q,
	input  logic [gpio_width-1:0]    gpio_in_q
);
	import soc_mem_pkg::*;

	typedef enum logic [1:0] {
		tgt_none,
		tgt_ram,
		tgt_gpio_out,
		tgt_gpio_in
	} tgt_e;

	byte_addr_t ram_off;           // Offset into RAM window
	tgt_e       tgt_d, tgt_q;      // Target of this / last request
	logic       ready_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign ram_off = addr - spram_base;

	always_comb begin
		tgt_d = tgt_none; // Unmapped hole by default
		if (ram_off < spram_bytes)
			tgt_d = tgt_ram;
		else if (addr[31:2] == gpio_out_addr[31:2])
			tgt_d = tgt_gpio_out;
		else if (addr[31:2] == gpio_in_addr[31:2])
			tgt_d = tgt_gpio_in;
	end

	// Strobes reach only the target that was hit
	assign ram_wen    = (req && tgt_d == tgt_ram)      ? wstrb : '0;
	assign gpio_we    = (req && tgt_d == tgt_gpio_out) ? wstrb : '0;
	assign ram_addr   = ram_off[16:2]; // RAM is read every cycle anyway
	assign ram_wdata  = wdata;
	assign gpio_wdata = wdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q <= 1'b0;
			tgt_q   <= tgt_none;
		end else begin
			ready_q <= req;                        // Fixed one-cycle latency
			tgt_q   <= req ? tgt_d : tgt_none;
		end
	end

	assign ready = ready_q;

	// Mux by the target recorded with the request, not the current one
	always_comb begin
		case (tgt_q)
			tgt_ram:      rdata = ram_rdata;
			tgt_gpio_out: rdata = word_t'(gpio_out_q); // Zero-extended
			tgt_gpio_in:  rdata = word_t'(gpio_in_q);
			default:      rdata = '0;
		endcase
	end

endmodule

/* src/gpio_regs.sv */
// GPIO register block.
// Output register with byte-lane writes, plus a two-flop synchronizer
// on the input pins for readback through the bus port.

module gpio_regs #(
	parameter int gpio_width = 8 // 1 to 32 pins
) (
	input  logic                  clk,
	input  logic                  rst,
	input  soc_mem_pkg::wstrb_t   we,        // Byte write enables
	input  soc_mem_pkg::word_t    wdata,
	output logic [gpio_width-1:0] gpio_out,
	input  logic [gpio_width-1:0] gpio_in,   // Asynchronous pins
	output logic [gpio_width-1:0] gpio_in_q  // Synchronized copy
);

	logic [gpio_width-1:0] gpio_in_meta; // First synchronizer stage

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Each pin follows the strobe of its byte lane.
	// Lanes above gpio_width have no pins and are dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			gpio_out <= '0;
		end else begin
			for (int i = 0; i < gpio_width; i++) begin
				if (we[i / 8])
					gpio_out[i] <= wdata[i];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Input synchronizer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		gpio_in_meta <= gpio_in;      // May go metastable
		gpio_in_q    <= gpio_in_meta; // Settled value
	end

endmodule

/* src/soc_mem_top.sv */
// Top level of the on-chip memory block.
// Connects the CPU request port to the 128 kB SPRAM and the GPIO block.
// One ready pulse per req, one cycle later, no back-pressure.

module soc_mem_top #(
	parameter int gpio_width = 8 // Number of GPIO pins, 1 to 32
) (
	input  logic                    clk,
	input  logic                    rst,
	// CPU side
	input  logic                    req,
	input  soc_mem_pkg::byte_addr_t addr,
	input  soc_mem_pkg::word_t      wdata,
	input  soc_mem_pkg::wstrb_t     wstrb,
	output soc_mem_pkg::word_t      rdata,
	output logic                    ready,
	// Pins
	input  logic [gpio_width-1:0]   gpio_in,
	output logic [gpio_width-1:0]   gpio_out
);
	import soc_mem_pkg::*;

	// RAM port
	wstrb_t      ram_wen;
	spram_addr_t ram_addr;
	word_t       ram_wdata;
	word_t       ram_rdata;

	// GPIO port
	wstrb_t                gpio_we;
	word_t                 gpio_wdata;
	logic [gpio_width-1:0] gpio_in_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instances
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	mem_bus_port #(
		.gpio_width(gpio_width)
	) mem_bus_port_inst (
		.clk(clk), .rst(rst),
		.req(req), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.rdata(rdata), .ready(ready),
		.ram_wen(ram_wen), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
		.gpio_we(gpio_we), .gpio_wdata(gpio_wdata),
		.gpio_out_q(gpio_out), .gpio_in_q(gpio_in_q) // Register fed back for readback
	);

	ice40up5k_spram ice40up5k_spram_inst (
		.clk(clk), .wen(ram_wen), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	gpio_regs #(
		.gpio_width(gpio_width)
	) gpio_regs_inst (
		.clk(clk), .rst(rst),
		.we(gpio_we), .wdata(gpio_wdata),
		.gpio_out(gpio_out), .gpio_in(gpio_in), .gpio_in_q(gpio_in_q)
	);

endmodule

/* verif/soc_mem_tb.sv */
// Testbench for the on-chip memory block.
// Runs a table of bus requests, then random word traffic checked against
// a reference memory, and prints the error counts and a verdict.

module soc_mem_tb;
	import soc_mem_pkg::*;

	localparam logic [1:0] op_rd   = 2'd0; // Read with rdata checked
	localparam logic [1:0] op_wr   = 2'd1; // Write with rdata ignored
	localparam logic [1:0] op_wr_z = 2'd2; // Write to a hole that reads zero
	localparam int max_entries = 200;

	typedef struct packed {
		logic [1:0] op;
		byte_addr_t addr;
		word_t      wdata;
		wstrb_t     strb;
		logic [7:0] gin;   // gpio_in pins
		word_t      exp;   // Expected rdata
		logic       chain; // Issued the cycle after the previous req
	} entry_t;

	logic       clk, rst, req, ready;
	byte_addr_t addr;
	word_t      wdata, rdata;
	wstrb_t     wstrb;
	logic [7:0] gpio_in, gpio_out;

	entry_t      tbl [0:max_entries-1];
	int          n_entries;
	int          err_count, timeout_count;
	integer      seed;
	logic [7:0]  gpio_exp;      // Expected output register
	word_t       ref_mem [0:31]; // Reference RAM words, one per slot
	logic [31:0] ref_known;     // Slots written at least once

	soc_mem_top #(
		.gpio_width(8)
	) soc_mem_top_inst (
		.clk(clk), .rst(rst),
		.req(req), .addr(addr), .wdata(wdata), .wstrb(wstrb),
		.rdata(rdata), .ready(ready),
		.gpio_in(gpio_in), .gpio_out(gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // Period 20
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			err_count++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic add_entry(input logic [1:0] op, input byte_addr_t a, input word_t d,
			input wstrb_t s, input logic [7:0] g, input word_t e, input logic ch);
		tbl[n_entries] = {op, a, d, s, g, e, ch};
		n_entries++;
	endtask

	// Old word with the strobed byte lanes replaced
	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
			input wstrb_t s);
		word_t m;
		m = old_w;
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				m[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return m;
	endfunction

	task automatic drive_entry(input entry_t e);
		req     <= 1'b1;
		addr    <= e.addr;
		wdata   <= e.wdata;
		wstrb   <= (e.op == op_rd) ? 4'h0 : e.strb; // Zero strobes = read
		gpio_in <= e.gin;
	endtask

	// Counts falling edges until ready or until 8 have passed
	task automatic wait_ready(output int waited);
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!ready && waited < 8);
		if (!ready) begin
			timeout_count++;
			$display("ready never came for request at time %0t", $time);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table runner
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_table();
		int     waited;
		entry_t e;
		for (int i = 0; i < n_entries; i++) begin
			e = tbl[i];
			if (i == 0 || !e.chain) begin
				@(negedge clk);
				check_value("ready", 0, ready); // No ready without a req
				@(posedge clk);
				drive_entry(e);
			end
			@(posedge clk); // Request taken here
			if (i + 1 < n_entries && tbl[i+1].chain)
				drive_entry(tbl[i+1]); // Overlap with this response
			else
				req <= 1'b0;
			wait_ready(waited);
			check_value("ready latency", 1, waited);
			if (e.op != op_rd && e.addr == gpio_out_addr && e.strb[0])
				gpio_exp = e.wdata[7:0]; // Only lane 0 has pins
			if (e.op != op_wr)
				check_value("rdata", e.exp, rdata);
			check_value("gpio_out", word_t'(gpio_exp), word_t'(gpio_out));
		end
	endtask

	task automatic build_table();
		n_entries = 0;
		// Pair and half boundaries
		add_entry(op_wr, 32'h0000_0000, 32'h0123_4567, 4'hf, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0000_fffc, 32'h89ab_cdef, 4'hf, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0001_0000, 32'hdead_beef, 4'hf, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0001_fffc, 32'hcafe_f00d, 4'hf, 8'h00, 32'h0, 1'b0);
		add_entry(op_rd, 32'h0000_0000, 32'h0, 4'h0, 8'h00, 32'h0123_4567, 1'b0);
		add_entry(op_rd, 32'h0000_fffc, 32'h0, 4'h0, 8'h00, 32'h89ab_cdef, 1'b0);
		add_entry(op_rd, 32'h0001_0000, 32'h0, 4'h0, 8'h00, 32'hdead_beef, 1'b0);
		add_entry(op_rd, 32'h0001_fffc, 32'h0, 4'h0, 8'h00, 32'hcafe_f00d, 1'b0);
		// Partial strobes merge lane by lane
		add_entry(op_wr, 32'h0000_0100, 32'h1122_3344, 4'hf, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0000_0100, 32'haabb_ccdd, 4'h2, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0000_0100, 32'h5566_7788, 4'hc, 8'h00, 32'h0, 1'b0);
		add_entry(op_wr, 32'h0000_0100, 32'h0000_00ee, 4'h1, 8'h00, 32'h0, 1'b0);
		add_entry(op_rd, 32'h0000_0100, 32'h0, 4'h0, 8'h00, 32'h5566_ccee, 1'b0);
		// GPIO with pins set well before the input read
		add_entry(op_wr, gpio_out_addr, 32'h0000_00a5, 4'h1, 8'h3c, 32'h0, 1'b0);
		add_entry(op_wr, gpio_out_addr, 32'h0000_ff00, 4'h2, 8'h3c, 32'h0, 1'b0);
		add_entry(op_rd, gpio_out_addr, 32'h0, 4'h0, 8'h3c, 32'h0000_00a5, 1'b0);
		add_entry(op_rd, gpio_in_addr, 32'h0, 4'h0, 8'h3c, 32'h0000_003c, 1'b0);
		// Back to back across pairs and targets
		add_entry(op_rd, 32'h0000_fffc, 32'h0, 4'h0, 8'h3c, 32'h89ab_cdef, 1'b0);
		add_entry(op_rd, 32'h0001_0000, 32'h0, 4'h0, 8'h3c, 32'hdead_beef, 1'b1);
		add_entry(op_rd, 32'h0000_0000, 32'h0, 4'h0, 8'h3c, 32'h0123_4567, 1'b1);
		add_entry(op_rd, 32'h0001_fffc, 32'h0, 4'h0, 8'h3c, 32'hcafe_f00d, 1'b1);
		add_entry(op_rd, gpio_in_addr, 32'h0, 4'h0, 8'h3c, 32'h0000_003c, 1'b1);
		add_entry(op_rd, 32'h0000_0100, 32'h0, 4'h0, 8'h3c, 32'h5566_ccee, 1'b1);
		add_entry(op_rd, gpio_out_addr, 32'h0, 4'h0, 8'h3c, 32'h0000_00a5, 1'b1);
		add_entry(op_rd, 32'h0000_fffc, 32'h0, 4'h0, 8'h3c, 32'h89ab_cdef, 1'b1);
		// Unmapped hole
		add_entry(op_wr_z, 32'h0100_0000, 32'hffff_ffff, 4'hf, 8'h3c, 32'h0, 1'b0);
		add_entry(op_rd, 32'h0100_0000, 32'h0, 4'h0, 8'h3c, 32'h0, 1'b0);
		add_entry(op_rd, 32'h0200_0008, 32'h0, 4'h0, 8'h3c, 32'h0, 1'b0);
		add_entry(op_rd, 32'h0000_0000, 32'h0, 4'h0, 8'h3c, 32'h0123_4567, 1'b0);
	endtask

	// Write then read back over 32 words spread across both pairs
	task automatic build_random();
		int         slot;
		int         idx;
		word_t      d;
		wstrb_t     s;
		byte_addr_t a;
		n_entries = 0;
		ref_known = '0;
		for (int k = 0; k < 64; k++) begin
			slot = $random(seed) & 31;
			idx  = (slot * 1031) & 32'h7fff;
			d    = $random(seed);
			s    = $random(seed);
			if (!ref_known[slot] || s == 4'h0) begin
				s               = 4'hf; // Unknown word goes in whole
				ref_known[slot] = 1'b1;
			end
			ref_mem[slot] = merge_bytes(ref_mem[slot], d, s);
			a = spram_base + idx * 4;
			add_entry(op_wr, a, d, s, 8'h3c, 32'h0, 1'b0);
			add_entry(op_rd, a, 32'h0, 4'h0, 8'h3c, ref_mem[slot], 1'b1);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		seed          = 32'h84ad_9d26;
		err_count     = 0;
		timeout_count = 0;
		n_entries     = 0;
		gpio_exp      = 8'h00;
		rst     <= 1'b1;
		req     <= 1'b0;
		addr    <= '0;
		wdata   <= '0;
		wstrb   <= '0;
		gpio_in <= '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("ready", 0, ready); // Quiet after reset
		check_value("gpio_out", 0, word_t'(gpio_out));
		build_table();
		run_table();
		build_random();
		run_table();
		$display("errors %0d timeouts %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
src/soc_mem_pkg.sv
src/spram_bank.sv
src/ice40up5k_spram.sv
src/mem_bus_port.sv
src/gpio_regs.sv
src/soc_mem_top.sv
verif/soc_mem_tb.sv

/* Bender.yml */
package:
  name: soc_mem

sources:
  # RTL in compile order
  - files:
      - src/soc_mem_pkg.sv
      - src/spram_bank.sv
      - src/ice40up5k_spram.sv
      - src/mem_bus_port.sv
      - src/gpio_regs.sv
      - src/soc_mem_top.sv

  # Simulation only
  - target: test
    files:
      - verif/soc_mem_tb.sv
